// ==== list.f ====
+incdir+verif
rtl/lockstep_pkg.sv
rtl/store_if.sv
rtl/bus_if.sv
rtl/core_exec.sv
rtl/bus_credit_tx.sv
rtl/proc_core.sv
rtl/hmr_unit.sv
rtl/lockstep_top.sv
verif/tb_lockstep_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the lockstep testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_lockstep_top -o tb_sim

out="$(./obj_dir/tb_sim)"
echo "$out"

if grep -q "TEST RESULT: PASS" <<< "$out"; then
    exit 0
fi
exit 1

// ==== verif/lockstep_model.svh ====
/*
 * Reference model for the lockstep testbench: per-core accumulators,
 * queues of expected bus writes and the DMR visibility rule
 */
`ifndef LOCKSTEP_MODEL_SVH
`define LOCKSTEP_MODEL_SVH

localparam int WriteW = $bits(hart_t) + $bits(addr_t) + $bits(data_t);

data_t             model_acc [2];
logic [WriteW-1:0] exp_q     [2][$];

function automatic void model_reset();
    for (int p = 0; p < 2; p++) begin
        model_acc[p] = '0;
        exp_q[p].delete();
    end
endfunction

// Commands take effect in send order, a STORE captures the accumulator
function automatic void model_apply(input int p, input op_e op, input data_t operand,
                                    input hart_t hart, input logic dmr);
    data_t next;
    next = model_acc[p];
    case (op)
        OP_LOAD:  next = operand;
        OP_ADD:   next = model_acc[p] + operand;
        OP_XOR:   next = model_acc[p] ^ operand;
        OP_STORE: exp_q[p].push_back({hart, operand[15:0], model_acc[p]});
        default:  next = model_acc[p];
    endcase
    model_acc[p] = next;
    // Shadow core follows core 0 in DMR
    if (dmr && p == 0) begin
        model_acc[1] = next;
    end
endfunction

// In DMR only port 0 may show activity
function automatic logic port_visible(input int p, input logic dmr);
    return (p == 0) || !dmr;
endfunction

`endif

// ==== verif/tb_lockstep_top.sv ====
/*
 * Testbench for lockstep_top: random command streams in independent mode,
 * bus credit back-pressure, DMR lockstep, mismatch detection and clear
 */
`timescale 1ns/1ps
`default_nettype none

module tb_lockstep_top;
    import lockstep_pkg::*;

    localparam int NumCores      = 2;
    localparam int CmdDepth      = 4;
    localparam int BusCredits    = 2;
    localparam int TimeoutCycles = 400;

    logic                  clk_i;
    logic                  arst_n_i;
    logic                  clear_i;
    logic                  dmr_mode_i;
    logic  [NumCores-1:0]  cmd_valid_i;
    op_e   [NumCores-1:0]  cmd_op_i;
    data_t [NumCores-1:0]  cmd_operand_i;
    hart_t [NumCores-1:0]  hart_id_i;
    logic  [NumCores-1:0]  cmd_credit_o;
    logic  [NumCores-1:0]  bus_valid_o;
    hart_t [NumCores-1:0]  bus_hart_o;
    addr_t [NumCores-1:0]  bus_addr_o;
    data_t [NumCores-1:0]  bus_data_o;
    logic  [NumCores-1:0]  bus_credit_i;
    logic                  dmr_failure_o;

    `include "lockstep_model.svh"

    // Testbench view of credits and counts per port
    int    cmd_cred  [2];
    int    sent      [2];
    int    got       [2];
    int    owed      [2];
    bit    rand_send [2];
    bit    ret_en;
    bit    fail_ok;
    int    value_errs;
    int    proto_errs;
    int    timeout_errs;
    string test_name;
    data_t load_val;
    int    n;

    lockstep_top #(
        .NumCores  (NumCores),
        .CmdDepth  (CmdDepth),
        .BusCredits(BusCredits)
    ) u_lockstep_top (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .clear_i      (clear_i),
        .dmr_mode_i   (dmr_mode_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_op_i     (cmd_op_i),
        .cmd_operand_i(cmd_operand_i),
        .hart_id_i    (hart_id_i),
        .cmd_credit_o (cmd_credit_o),
        .bus_valid_o  (bus_valid_o),
        .bus_hart_o   (bus_hart_o),
        .bus_addr_o   (bus_addr_o),
        .bus_data_o   (bus_data_o),
        .bus_credit_i (bus_credit_i),
        .dmr_failure_o(dmr_failure_o)
    );

    always #10 clk_i = ~clk_i;

    task automatic value_fail(input string what, input logic [63:0] exp, input logic [63:0] act);
        value_errs++;
        $display("FAIL %s %s expected %0h actual %0h", test_name, what, exp, act);
    endtask

    task automatic proto_fail(input string msg);
        proto_errs++;
        $display("ERROR %s: %s", test_name, msg);
    endtask

    task automatic finish_run();
        $display("Errors: value %0d, protocol %0d, timeout %0d",
                 value_errs, proto_errs, timeout_errs);
        if (value_errs + proto_errs + timeout_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        timeout_errs++;
        $display("ERROR %s: timed out waiting for %s", test_name, what);
        finish_run();
    endtask

    // Outputs are registered or settled since the last rising edge
    task automatic observe();
        logic [WriteW-1:0] exp_w;
        logic [WriteW-1:0] act_w;
        for (int p = 0; p < NumCores; p++) begin
            if (cmd_credit_o[p]) begin
                cmd_cred[p]++;
                got[p]++;
            end
            if (cmd_cred[p] > CmdDepth) begin
                proto_fail($sformatf("port %0d returned more command credits than sent", p));
            end
            if (bus_valid_o[p]) begin
                owed[p]++;
                if (owed[p] > BusCredits) begin
                    proto_fail($sformatf("port %0d wrote without a bus credit", p));
                end
                act_w = {bus_hart_o[p], bus_addr_o[p], bus_data_o[p]};
                if (exp_q[p].size() == 0) begin
                    proto_fail($sformatf("port %0d wrote with no write expected", p));
                end else begin
                    exp_w = exp_q[p].pop_front();
                    if (act_w !== exp_w) begin
                        value_fail($sformatf("bus_write[%0d]", p), 64'(exp_w), 64'(act_w));
                    end
                end
            end
            if (!port_visible(p, dmr_mode_i) && (bus_valid_o[p] || cmd_credit_o[p])) begin
                proto_fail($sformatf("shadow port %0d showed activity in DMR mode", p));
            end
        end
        if (!fail_ok && dmr_failure_o) begin
            value_fail("dmr_failure", 64'(0), 64'(dmr_failure_o));
        end
    endtask

    task automatic issue(input int p, input op_e op, input data_t operand);
        cmd_valid_i[p]   = 1'b1;
        cmd_op_i[p]      = op;
        cmd_operand_i[p] = operand;
        cmd_cred[p]--;
        sent[p]++;
        model_apply(p, op, operand, hart_id_i[p], dmr_mode_i);
    endtask

    // Random commands and late credit returns
    task automatic drive();
        for (int p = 0; p < NumCores; p++) begin
            cmd_valid_i[p]  = 1'b0;
            bus_credit_i[p] = 1'b0;
            if (rand_send[p] && cmd_cred[p] > 0 && $urandom_range(1, 0) == 1) begin
                issue(p, op_e'(2'($urandom_range(3, 0))), $urandom());
            end
            if (ret_en && owed[p] > 0 && $urandom_range(3, 0) == 0) begin
                bus_credit_i[p] = 1'b1;
                owed[p]--;
            end
        end
    endtask

    task automatic cycle();
        @(negedge clk_i);
        observe();
        drive();
    endtask

    task automatic send_one(input int p, input op_e op, input data_t operand);
        int waited;
        waited = 0;
        while (cmd_cred[p] == 0 && waited < TimeoutCycles) begin
            cycle();
            waited++;
        end
        if (cmd_cred[p] == 0) begin
            timed_out("a command credit");
        end else begin
            cycle();
            issue(p, op, operand);
        end
    endtask

    function automatic bit all_idle();
        bit idle;
        idle = 1'b1;
        for (int p = 0; p < NumCores; p++) begin
            if (cmd_cred[p] != CmdDepth || exp_q[p].size() != 0 || owed[p] != 0) begin
                idle = 1'b0;
            end
        end
        return idle;
    endfunction

    // Stop sending, return all bus credits, wait for every write
    task automatic drain();
        int waited;
        rand_send[0] = 1'b0;
        rand_send[1] = 1'b0;
        ret_en       = 1'b1;
        waited       = 0;
        while (!all_idle() && waited < TimeoutCycles) begin
            cycle();
            waited++;
        end
        if (!all_idle()) begin
            timed_out("queues to drain");
        end else begin
            for (int p = 0; p < NumCores; p++) begin
                if (got[p] != sent[p]) begin
                    value_fail($sformatf("cmd_credits[%0d]", p), 64'(sent[p]), 64'(got[p]));
                end
            end
        end
    endtask

    task automatic clear_all();
        cycle();
        clear_i = 1'b1;
        cycle();
        clear_i = 1'b0;
        model_reset();
        for (int p = 0; p < NumCores; p++) begin
            cmd_cred[p] = CmdDepth;
            sent[p]     = 0;
            got[p]      = 0;
        end
    endtask

    initial begin
        void'($urandom(41111));
        clk_i         = 1'b0;
        arst_n_i      = 1'b0;
        clear_i       = 1'b0;
        dmr_mode_i    = 1'b0;
        cmd_valid_i   = '0;
        cmd_op_i      = {OP_LOAD, OP_LOAD};
        cmd_operand_i = '0;
        hart_id_i     = {4'hA, 4'h5};
        bus_credit_i  = '0;
        ret_en        = 1'b1;
        fail_ok       = 1'b0;
        value_errs    = 0;
        proto_errs    = 0;
        timeout_errs  = 0;
        model_reset();
        for (int p = 0; p < NumCores; p++) begin
            cmd_cred[p]  = CmdDepth;
            sent[p]      = 0;
            got[p]       = 0;
            owed[p]      = 0;
            rand_send[p] = 1'b0;
        end
        repeat (8) @(negedge clk_i);
        arst_n_i = 1'b1;

        test_name = "reset_values";
        if (bus_valid_o !== '0 || cmd_credit_o !== '0 || dmr_failure_o !== 1'b0) begin
            value_fail("outputs", 64'(0), 64'({bus_valid_o, cmd_credit_o, dmr_failure_o}));
        end
        send_one(0, OP_STORE, $urandom());
        send_one(1, OP_STORE, $urandom());
        drain();

        test_name    = "independent";
        rand_send[0] = 1'b1;
        rand_send[1] = 1'b1;
        repeat (300) cycle();
        drain();

        // Hold all bus credits back, then release them late
        test_name    = "credit_hold";
        ret_en       = 1'b0;
        rand_send[0] = 1'b1;
        rand_send[1] = 1'b1;
        repeat (60) cycle();
        drain();

        test_name = "lockstep";
        clear_all();
        cycle();
        dmr_mode_i   = 1'b1;
        rand_send[0] = 1'b1;
        repeat (200) cycle();
        drain();

        test_name = "mismatch";
        cycle();
        dmr_mode_i = 1'b0;
        load_val   = $urandom();
        send_one(0, OP_LOAD, load_val);
        send_one(1, OP_LOAD, load_val ^ 32'h0000_0100);
        drain();
        cycle();
        dmr_mode_i = 1'b1;
        fail_ok    = 1'b1;
        send_one(0, OP_STORE, $urandom());
        n = 0;
        while (!dmr_failure_o && n < TimeoutCycles) begin
            cycle();
            n++;
        end
        if (!dmr_failure_o) begin
            timed_out("dmr_failure_o to rise");
        end else begin
            repeat (10) begin
                cycle();
                if (dmr_failure_o !== 1'b1) begin
                    value_fail("dmr_failure_hold", 64'(1), 64'(dmr_failure_o));
                end
            end
            drain();
            clear_all();
            fail_ok = 1'b0;
            if (dmr_failure_o !== 1'b0) begin
                value_fail("dmr_failure_clear", 64'(0), 64'(dmr_failure_o));
            end
            repeat (5) cycle();
            finish_run();
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lockstep_top.sv ====
/*
 * Top level: per-core accumulator engines behind the redundancy unit,
 * with plain per-core command and bus ports
 */
`timescale 1ns/1ps
`default_nettype none

module lockstep_top #(
    parameter int unsigned NumCores   = lockstep_pkg::DEF_NUM_CORES,
    parameter int unsigned CmdDepth   = lockstep_pkg::DEF_CMD_DEPTH,
    parameter int unsigned BusCredits = lockstep_pkg::DEF_BUS_CREDITS
) (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    input  logic                               clear_i,
    input  logic                               dmr_mode_i,
    input  logic                [NumCores-1:0] cmd_valid_i,
    input  lockstep_pkg::op_e   [NumCores-1:0] cmd_op_i,
    input  lockstep_pkg::data_t [NumCores-1:0] cmd_operand_i,
    input  lockstep_pkg::hart_t [NumCores-1:0] hart_id_i,
    output logic                [NumCores-1:0] cmd_credit_o,
    output logic                [NumCores-1:0] bus_valid_o,
    output lockstep_pkg::hart_t [NumCores-1:0] bus_hart_o,
    output lockstep_pkg::addr_t [NumCores-1:0] bus_addr_o,
    output lockstep_pkg::data_t [NumCores-1:0] bus_data_o,
    input  logic                [NumCores-1:0] bus_credit_i,
    output logic                               dmr_failure_o
);
    import lockstep_pkg::*;

    // Redundancy unit to core inputs
    logic  [NumCores-1:0] core_cmd_valid;
    op_e   [NumCores-1:0] core_cmd_op;
    data_t [NumCores-1:0] core_cmd_operand;
    hart_t [NumCores-1:0] core_hart_id;
    logic  [NumCores-1:0] core_cmd_credit;

    bus_if u_bus_if [NumCores] ();

    for (genvar i = 0; i < NumCores; i++) begin : gen_core
        proc_core #(
            .CmdDepth  (CmdDepth),
            .BusCredits(BusCredits)
        ) u_proc_core (
            .clk_i        (clk_i),
            .arst_n_i     (arst_n_i),
            .clear_i      (clear_i),
            .cmd_valid_i  (core_cmd_valid[i]),
            .cmd_op_i     (core_cmd_op[i]),
            .cmd_operand_i(core_cmd_operand[i]),
            .hart_id_i    (core_hart_id[i]),
            .cmd_credit_o (core_cmd_credit[i]),
            .bus          (u_bus_if[i])
        );
    end

    hmr_unit #(
        .NumCores(NumCores)
    ) u_hmr_unit (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .clear_i           (clear_i),
        .dmr_mode_i        (dmr_mode_i),
        .sys_cmd_valid_i   (cmd_valid_i),
        .sys_cmd_op_i      (cmd_op_i),
        .sys_cmd_operand_i (cmd_operand_i),
        .sys_hart_id_i     (hart_id_i),
        .sys_bus_credit_i  (bus_credit_i),
        .sys_cmd_credit_o  (cmd_credit_o),
        .sys_bus_valid_o   (bus_valid_o),
        .sys_bus_hart_o    (bus_hart_o),
        .sys_bus_addr_o    (bus_addr_o),
        .sys_bus_data_o    (bus_data_o),
        .core_cmd_valid_o  (core_cmd_valid),
        .core_cmd_op_o     (core_cmd_op),
        .core_cmd_operand_o(core_cmd_operand),
        .core_hart_id_o    (core_hart_id),
        .core_cmd_credit_i (core_cmd_credit),
        .core_bus          (u_bus_if),
        .dmr_failure_o     (dmr_failure_o)
    );

endmodule

`default_nettype wire

// ==== rtl/hmr_unit.sv ====
/*
 * Redundancy unit: input replication in DMR mode,
 * per-cycle output comparison and the sticky failure flag.
 * Pass-through in independent mode or with a single core.
 */
`timescale 1ns/1ps
`default_nettype none

module hmr_unit #(
    parameter int unsigned NumCores = lockstep_pkg::DEF_NUM_CORES
) (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                clear_i,
    input  logic                                dmr_mode_i,
    input  logic                 [NumCores-1:0] sys_cmd_valid_i,
    input  lockstep_pkg::op_e    [NumCores-1:0] sys_cmd_op_i,
    input  lockstep_pkg::data_t  [NumCores-1:0] sys_cmd_operand_i,
    input  lockstep_pkg::hart_t  [NumCores-1:0] sys_hart_id_i,
    input  logic                 [NumCores-1:0] sys_bus_credit_i,
    output logic                 [NumCores-1:0] sys_cmd_credit_o,
    output logic                 [NumCores-1:0] sys_bus_valid_o,
    output lockstep_pkg::hart_t  [NumCores-1:0] sys_bus_hart_o,
    output lockstep_pkg::addr_t  [NumCores-1:0] sys_bus_addr_o,
    output lockstep_pkg::data_t  [NumCores-1:0] sys_bus_data_o,
    output logic                 [NumCores-1:0] core_cmd_valid_o,
    output lockstep_pkg::op_e    [NumCores-1:0] core_cmd_op_o,
    output lockstep_pkg::data_t  [NumCores-1:0] core_cmd_operand_o,
    output lockstep_pkg::hart_t  [NumCores-1:0] core_hart_id_o,
    input  logic                 [NumCores-1:0] core_cmd_credit_i,
    bus_if.sys                                  core_bus [NumCores],
    output logic                                dmr_failure_o
);

    localparam bit HasPair = (NumCores == 2);

    logic dmr_active;

    assign dmr_active = HasPair && dmr_mode_i;

    for (genvar i = 0; i < NumCores; i++) begin : gen_route
        // Core 1 shadows core 0 while DMR is on
        logic shadow;

        assign shadow = dmr_active && (i != 0);

        assign core_cmd_valid_o[i]   = shadow ? sys_cmd_valid_i[0]   : sys_cmd_valid_i[i];
        assign core_cmd_op_o[i]      = shadow ? sys_cmd_op_i[0]      : sys_cmd_op_i[i];
        assign core_cmd_operand_o[i] = shadow ? sys_cmd_operand_i[0] : sys_cmd_operand_i[i];
        assign core_hart_id_o[i]     = shadow ? sys_hart_id_i[0]     : sys_hart_id_i[i];
        assign core_bus[i].bus_credit = shadow ? sys_bus_credit_i[0] : sys_bus_credit_i[i];

        // Shadow outputs hidden from the system
        assign sys_cmd_credit_o[i] = shadow ? 1'b0 : core_cmd_credit_i[i];
        assign sys_bus_valid_o[i]  = shadow ? 1'b0 : core_bus[i].bus_valid;
        assign sys_bus_hart_o[i]   = shadow ? '0   : core_bus[i].bus_hart;
        assign sys_bus_addr_o[i]   = shadow ? '0   : core_bus[i].bus_addr;
        assign sys_bus_data_o[i]   = shadow ? '0   : core_bus[i].bus_data;
    end

    if (HasPair) begin : gen_dmr
        logic mismatch;
        logic payload_diff;
        logic failure_q;

        // Payload only compared while a request is out
        assign payload_diff = (core_bus[0].bus_hart != core_bus[1].bus_hart)
                           || (core_bus[0].bus_addr != core_bus[1].bus_addr)
                           || (core_bus[0].bus_data != core_bus[1].bus_data);

        assign mismatch = dmr_active
                       && ((core_cmd_credit_i[0] != core_cmd_credit_i[1])
                        || (core_bus[0].bus_valid != core_bus[1].bus_valid)
                        || (core_bus[0].bus_valid && payload_diff));

        // Sticky until clear or reset
        always_ff @(posedge clk_i or negedge arst_n_i) begin
            if (!arst_n_i) begin
                failure_q <= 1'b0;
            end else if (clear_i) begin
                failure_q <= 1'b0;
            end else if (mismatch) begin
                failure_q <= 1'b1;
            end
        end

        assign dmr_failure_o = failure_q;
    end else begin : gen_single
        assign dmr_failure_o = 1'b0;
    end

endmodule

`default_nettype wire

// ==== rtl/proc_core.sv ====
/*
 * One accumulator core: executor plus bus transmitter
 */
`timescale 1ns/1ps
`default_nettype none

module proc_core #(
    parameter int unsigned CmdDepth   = lockstep_pkg::DEF_CMD_DEPTH,
    parameter int unsigned BusCredits = lockstep_pkg::DEF_BUS_CREDITS
) (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                clear_i,
    input  logic                cmd_valid_i,
    input  lockstep_pkg::op_e   cmd_op_i,
    input  lockstep_pkg::data_t cmd_operand_i,
    input  lockstep_pkg::hart_t hart_id_i,
    output logic                cmd_credit_o,
    bus_if.core                 bus
);

    // Executor to transmitter store path
    store_if u_store_if ();

    core_exec #(
        .CmdDepth(CmdDepth)
    ) u_core_exec (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .clear_i      (clear_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_op_i     (cmd_op_i),
        .cmd_operand_i(cmd_operand_i),
        .cmd_credit_o (cmd_credit_o),
        .store        (u_store_if.exec)
    );

    bus_credit_tx #(
        .BusCredits(BusCredits)
    ) u_bus_credit_tx (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .hart_id_i(hart_id_i),
        .store    (u_store_if.tx),
        .bus      (bus)
    );

endmodule

`default_nettype wire

// ==== rtl/bus_credit_tx.sv ====
/*
 * Bus credit counter and registered write request output
 */
`timescale 1ns/1ps
`default_nettype none

module bus_credit_tx #(
    parameter int unsigned BusCredits = lockstep_pkg::DEF_BUS_CREDITS
) (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  lockstep_pkg::hart_t hart_id_i,
    store_if.tx                 store,
    bus_if.core                 bus
);

    localparam int unsigned CntW = $clog2(BusCredits + 1);

    logic [CntW-1:0] credit_cnt;
    logic            accept;

    assign store.store_ready = (credit_cnt != '0);
    assign accept            = store.store_valid && store.store_ready;

    // Spend and return may land in the same cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_cnt <= CntW'(BusCredits);
        end else begin
            credit_cnt <= credit_cnt - CntW'(accept) + CntW'(bus.bus_credit);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus.bus_valid <= 1'b0;
        end else begin
            bus.bus_valid <= accept;
        end
    end

    // Request payload, only meaningful while bus_valid is high
    always_ff @(posedge clk_i) begin
        if (accept) begin
            bus.bus_hart <= hart_id_i;
            bus.bus_addr <= store.store_addr;
            bus.bus_data <= store.store_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/core_exec.sv ====
/*
 * Command queue and accumulator execution unit.
 * Retires one command per cycle in order, STOREs wait for store_ready.
 */
`timescale 1ns/1ps
`default_nettype none

module core_exec #(
    parameter int unsigned CmdDepth = lockstep_pkg::DEF_CMD_DEPTH
) (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                clear_i,
    input  logic                cmd_valid_i,
    input  lockstep_pkg::op_e   cmd_op_i,
    input  lockstep_pkg::data_t cmd_operand_i,
    output logic                cmd_credit_o,
    store_if.exec               store
);
    import lockstep_pkg::*;

    localparam int unsigned PtrW = (CmdDepth > 1) ? $clog2(CmdDepth) : 1;
    localparam int unsigned CntW = $clog2(CmdDepth + 1);

    op_e             op_q      [CmdDepth];
    data_t           operand_q [CmdDepth];
    logic [PtrW-1:0] wr_ptr;
    logic [PtrW-1:0] rd_ptr;
    logic [CntW-1:0] count;
    data_t           acc;

    op_e   head_op;
    data_t head_operand;
    logic  head_valid;
    logic  head_is_store;
    logic  retire;

    // Wrap also covers depths that are not a power of two
    function automatic logic [PtrW-1:0] ptr_next(input logic [PtrW-1:0] ptr);
        logic [PtrW-1:0] nxt;
        nxt = (ptr == PtrW'(CmdDepth - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    assign head_op       = op_q[rd_ptr];
    assign head_operand  = operand_q[rd_ptr];
    assign head_valid    = (count != '0);
    assign head_is_store = (head_op == OP_STORE);

    // Store waits at the head until the transmitter holds a credit
    assign retire       = head_valid && !clear_i && (!head_is_store || store.store_ready);
    assign cmd_credit_o = retire;

    assign store.store_valid = head_valid && head_is_store && !clear_i;
    assign store.store_addr  = head_operand[$bits(addr_t)-1:0];
    assign store.store_data  = acc;

    // Queue storage
    always_ff @(posedge clk_i) begin
        if (cmd_valid_i) begin
            op_q[wr_ptr]      <= cmd_op_i;
            operand_q[wr_ptr] <= cmd_operand_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (cmd_valid_i) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (retire) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            count <= count + CntW'(cmd_valid_i) - CntW'(retire);
        end
    end

    // Accumulator update on retirement
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            acc <= '0;
        end else if (clear_i) begin
            acc <= '0;
        end else if (retire) begin
            case (head_op)
                OP_LOAD: acc <= head_operand;
                OP_ADD:  acc <= acc + head_operand;
                OP_XOR:  acc <= acc ^ head_operand;
                default: acc <= acc;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/bus_if.sv ====
/*
 * One bus write request channel with its credit return
 */
`timescale 1ns/1ps
`default_nettype none

interface bus_if;
    import lockstep_pkg::*;

    // Request side, driven by the core
    logic  bus_valid;
    hart_t bus_hart;
    addr_t bus_addr;
    data_t bus_data;

    // One-cycle pulse, returns a single credit
    logic  bus_credit;

    modport core (
        output bus_valid,
        output bus_hart,
        output bus_addr,
        output bus_data,
        input  bus_credit
    );

    modport sys (
        input  bus_valid,
        input  bus_hart,
        input  bus_addr,
        input  bus_data,
        output bus_credit
    );

endinterface

`default_nettype wire

// ==== rtl/store_if.sv ====
/*
 * Store handshake between a core's executor and its bus transmitter
 */
`timescale 1ns/1ps
`default_nettype none

interface store_if;
    import lockstep_pkg::*;

    logic  store_valid;
    addr_t store_addr;
    data_t store_data;
    // High while at least one bus credit is held
    logic  store_ready;

    modport exec (
        output store_valid,
        output store_addr,
        output store_data,
        input  store_ready
    );

    modport tx (
        input  store_valid,
        input  store_addr,
        input  store_data,
        output store_ready
    );

endinterface

`default_nettype wire

// ==== rtl/lockstep_pkg.sv ====
/*
 * Shared types for the lockstep compute subsystem:
 * data, address and hart id words, command opcodes,
 * and default core count, queue depth and bus credit values
 */
`default_nettype none

package lockstep_pkg;

    // Accumulator and bus data word
    typedef logic [31:0] data_t;

    // Bus write address, low bits of a STORE operand
    typedef logic [15:0] addr_t;

    // Core identifier tagged on every bus request
    typedef logic [3:0] hart_t;

    // Command opcodes
    typedef enum logic [1:0] {
        OP_LOAD  = 2'd0,
        OP_ADD   = 2'd1,
        OP_XOR   = 2'd2,
        OP_STORE = 2'd3
    } op_e;

    // Two cores so that DMR is available by default
    localparam int unsigned DEF_NUM_CORES = 2;

    // Command queue depth, equal to the initial command credits
    localparam int unsigned DEF_CMD_DEPTH = 4;

    // Outstanding bus writes allowed before a credit returns
    localparam int unsigned DEF_BUS_CREDITS = 2;

endpackage

`default_nettype wire
